/* compile.f */
+incdir+dv
hw/llc_cfg_pkg.sv
hw/tag_store_pkg.sv
hw/tag_array.sv
hw/tag_match.sv
hw/victim_select.sv
hw/tag_store_ctrl.sv
hw/resp_spill_reg.sv
hw/tag_store.sv
dv/tag_store_tb.sv

/* dv/tag_store_model.svh */
`ifndef TAG_STORE_MODEL_SVH
`define TAG_STORE_MODEL_SVH

// Mirror of the tag banks, one entry per way and set
tag_entry_t mirror_mem [NumWays][NumSets];
// Round-robin victim pointer, starts at way 0
int mirror_ptr;

// Empty banks and pointer at way 0, as after reset
function automatic void reset_mirror();
  for (int w = 0; w < NumWays; w++) begin
    for (int s = 0; s < NumSets; s++) begin
      mirror_mem[w][s] = '0;
    end
  end
  mirror_ptr = 0;
endfunction

// Way of the set that holds this tag in any way, -1 if none
function automatic int find_tag(index_t idx, tag_t tag);
  for (int w = 0; w < NumWays; w++) begin
    if (mirror_mem[w][idx].valid && (mirror_mem[w][idx].tag == tag)) begin
      return w;
    end
  end
  return -1;
endfunction

// Lowest invalid eligible way first
// Otherwise first eligible way at or after the pointer, pointer moves past it
function automatic int pick_victim(way_mask_t mask, way_mask_t lock, index_t idx);
  way_mask_t elig;
  int        way;
  elig = mask & ~lock;
  for (int w = 0; w < NumWays; w++) begin
    if (elig[w] && !mirror_mem[w][idx].valid) begin
      return w;
    end
  end
  for (int n = 0; n < NumWays; n++) begin
    way = (mirror_ptr + n) % NumWays;
    if (elig[way]) begin
      mirror_ptr = (way + 1) % NumWays;
      return way;
    end
  end
  return -1;
endfunction

// Expected response of one accepted request, mirror updated like the array
function automatic store_res_t expect_response(store_req_t req, way_mask_t lock);
  store_res_t res;
  tag_entry_t ent;
  int         way;
  res = '0;
  way = -1;
  if (req.mode == Flush) begin
    for (int w = 0; w < NumWays; w++) begin
      if (req.way_mask[w]) begin
        way = w;
      end
    end
    ent             = mirror_mem[way][req.index];
    res.way_mask    = req.way_mask;
    res.evict       = ent.valid & ent.dirty;
    res.evict_tag   = ent.tag;
    // Flushed entry is cleared to zeros
    mirror_mem[way][req.index] = '0;
    return res;
  end
  // Hit needs a masked, valid way with equal tag
  for (int w = 0; w < NumWays; w++) begin
    if (req.way_mask[w] && mirror_mem[w][req.index].valid &&
        (mirror_mem[w][req.index].tag == req.tag)) begin
      way = w;
    end
  end
  if (way >= 0) begin
    res.way_mask[way] = 1'b1;
    res.hit           = 1'b1;
    if (req.dirty) begin
      mirror_mem[way][req.index].dirty = 1'b1;
    end
  end else begin
    way               = pick_victim(req.way_mask, lock, req.index);
    ent               = mirror_mem[way][req.index];
    res.way_mask[way] = 1'b1;
    res.evict         = ent.valid & ent.dirty;
    // Old tag is reported even when nothing is written back
    res.evict_tag     = ent.tag;
    mirror_mem[way][req.index] = '{valid: 1'b1, dirty: req.dirty, tag: req.tag};
  end
  return res;
endfunction

`endif

/* dv/tag_store_tb.sv */
`timescale 1ns/1ps

module tag_store_tb;

  import llc_cfg_pkg::*;
  import tag_store_pkg::*;

  // Random requests after the directed ones
  localparam int NumReqs       = 400;
  localparam int NumDirected   = 4;
  localparam int TimeoutCycles = (NumReqs + NumDirected) * 20 + 200;

  logic       clk_i;
  logic       rst_i;
  store_req_t req_i;
  logic       valid_i;
  logic       ready_o;
  store_res_t res_o;
  logic       valid_o;
  logic       ready_i;
  way_mask_t  spm_lock_i;

  // Expected responses in request order
  store_res_t exp_q [$];

  `include "tag_store_model.svh"

  tag_store DUT (
    .clk_i,
    .rst_i,
    .req_i,
    .valid_i,
    .ready_o,
    .res_o,
    .valid_o,
    .ready_i,
    .spm_lock_i
  );

  initial begin : proc_clk
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Prints the reason and the fail message and stops the run
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic compare_res(input string name, input store_res_t got, input store_res_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail at time %0t: %s got %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic compare_way(input string name, input way_mask_t got, input way_mask_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail at time %0t: %s got %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail at time %0t: %s got %b, expected %b", $time, name, got, exp));
    end
  endtask

  function automatic store_req_t make_req(store_mode_e mode, way_mask_t mask, index_t idx,
                                          tag_t tag, logic dirty);
    store_req_t req;
    req.mode     = mode;
    req.way_mask = mask;
    req.index    = idx;
    req.tag      = tag;
    req.dirty    = dirty;
    return req;
  endfunction

  // Four sets and four tags so that hits and full sets are common
  function automatic store_req_t random_req();
    store_req_t req;
    int         way;
    req       = '0;
    req.index = index_t'($urandom_range(0, 3));
    req.tag   = tag_t'($urandom_range(0, 3) * 37 + 5);
    req.dirty = 1'($urandom_range(0, 1));
    if ($urandom_range(0, 4) == 0) begin
      req.mode     = Flush;
      req.way_mask = way_mask_t'(1) << $urandom_range(0, NumWays - 1);
      return req;
    end
    req.mode     = Lookup;
    req.way_mask = way_mask_t'($urandom_range(1, 2**NumWays - 1));
    // At least one way must stay free of the lock
    if ((req.way_mask & ~spm_lock_i) == '0) begin
      for (int w = 0; w < NumWays; w++) begin
        if (!spm_lock_i[w] && ((req.way_mask & ~spm_lock_i) == '0)) begin
          req.way_mask[w] = 1'b1;
        end
      end
    end
    // A stored tag is always looked up in its way, so no set holds it twice
    way = find_tag(req.index, req.tag);
    if (way >= 0) begin
      req.way_mask[way] = 1'b1;
    end
    return req;
  endfunction

  // Starts on a falling edge and returns on the falling edge after acceptance
  task automatic send_req(input store_req_t req);
    req_i   = req;
    valid_i = 1'b1;
    @(posedge clk_i);
    while (!ready_o) begin
      @(posedge clk_i);
    end
    exp_q.push_back(expect_response(req, spm_lock_i));
    @(negedge clk_i);
    valid_i = 1'b0;
  endtask

  // All responses taken means the DUT is idle
  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
  endtask

  initial begin : proc_stim
    void'($urandom(32'hc376));
    rst_i      = 1'b1;
    valid_i    = 1'b0;
    req_i      = '0;
    spm_lock_i = '0;
    reset_mirror();
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    // Idle after reset
    @(posedge clk_i);
    check_level("ready_o", ready_o, 1'b1);
    check_level("valid_o", valid_o, 1'b0);
    @(negedge clk_i);

    // Miss into way 0, dirty hit, flush with write-back, miss again
    send_req(make_req(Lookup, '1, index_t'(0), tag_t'(5), 1'b0));
    send_req(make_req(Lookup, '1, index_t'(0), tag_t'(5), 1'b1));
    send_req(make_req(Flush, way_mask_t'(1), index_t'(0), tag_t'(0), 1'b0));
    send_req(make_req(Lookup, '1, index_t'(0), tag_t'(5), 1'b0));

    for (int i = 0; i < NumReqs; i++) begin
      // Lock only changes with nothing in flight and never covers all ways
      if ($urandom_range(0, 15) == 0) begin
        wait_drain();
        spm_lock_i = way_mask_t'($urandom_range(0, 2**NumWays - 2));
      end
      send_req(random_req());
      if ($urandom_range(0, 3) == 0) begin
        @(negedge clk_i);
      end
    end
    wait_drain();
    repeat (2) @(negedge clk_i);
    $display("Done: no errors");
    $finish;
  end

  // Consumer with random ready_i that checks order and hold under back-pressure
  // The oldest expected response must sit on res_o for as long as valid_o is high
  initial begin : proc_resp
    store_res_t exp_res;
    logic       stalled;
    ready_i = 1'b0;
    stalled = 1'b0;
    @(posedge clk_i);
    while (rst_i) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
    forever begin
      ready_i = ($urandom_range(0, 9) < 7);
      @(posedge clk_i);
      if (stalled) begin
        check_level("valid_o", valid_o, 1'b1);
      end
      if (valid_o) begin
        if (exp_q.size() == 0) begin
          abort_run("A response arrived with no request outstanding");
        end else begin
          exp_res = exp_q[0];
          compare_way("res_o.way_mask", res_o.way_mask, exp_res.way_mask);
          compare_res("res_o", res_o, exp_res);
          if (ready_i) begin
            void'(exp_q.pop_front());
          end
        end
      end
      stalled = valid_o && !ready_i;
      @(negedge clk_i);
    end
  end

  initial begin : proc_watchdog
    repeat (TimeoutCycles) @(posedge clk_i);
    abort_run("Timeout: the run took longer than the watchdog allows");
  end

endmodule

/* hw/tag_store.sv */
`timescale 1ns/1ps

module tag_store (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  tag_store_pkg::store_req_t req_i,
  input  logic                      valid_i,
  output logic                      ready_o,
  output tag_store_pkg::store_res_t res_o,
  output logic                      valid_o,
  input  logic                      ready_i,
  input  llc_cfg_pkg::way_mask_t    spm_lock_i
);

  import llc_cfg_pkg::*;
  import tag_store_pkg::*;

  // Registered request, shared by compare and victim logic
  store_req_t               req_q;
  // Array strobes
  way_mask_t                ram_req;
  way_mask_t                ram_we;
  index_t                   ram_index;
  tag_entry_t               ram_wdata;
  // Array read side
  tag_entry_t [NumWays-1:0] ram_rdata;
  way_mask_t                ram_rvalid;
  // Compare results
  way_mask_t                hit;
  way_mask_t                tag_val;
  way_mask_t                tag_dirty;
  logic                     sel_dirty;
  // Victim choice
  logic                     evict_req;
  way_mask_t                victim;
  logic                     evict_flag;
  logic                     victim_valid;
  // Into the output register
  store_res_t               res;
  logic                     res_valid;
  logic                     res_ready;

  tag_store_ctrl i_ctrl (
    .clk_i,
    .rst_i,
    .req_i,
    .valid_i,
    .rvalid_i       ( ram_rvalid   ),
    .hit_i          ( hit          ),
    .sel_dirty_i    ( sel_dirty    ),
    .res_way_i      ( res.way_mask ),
    .victim_valid_i ( victim_valid ),
    .res_ready_i    ( res_ready    ),
    .ready_o,
    .req_q_o        ( req_q        ),
    .ram_req_o      ( ram_req      ),
    .ram_we_o       ( ram_we       ),
    .ram_index_o    ( ram_index    ),
    .ram_wdata_o    ( ram_wdata    ),
    .evict_req_o    ( evict_req    ),
    .res_valid_o    ( res_valid    )
  );

  tag_array i_array (
    .clk_i,
    .rst_i,
    .req_i    ( ram_req    ),
    .we_i     ( ram_we     ),
    .index_i  ( ram_index  ),
    .wdata_i  ( ram_wdata  ),
    .rdata_o  ( ram_rdata  ),
    .rvalid_o ( ram_rvalid )
  );

  tag_match i_match (
    .rdata_i     ( ram_rdata  ),
    .req_q_i     ( req_q      ),
    .victim_i    ( victim     ),
    .evict_i     ( evict_flag ),
    .hit_o       ( hit        ),
    .val_o       ( tag_val    ),
    .dirty_o     ( tag_dirty  ),
    .sel_dirty_o ( sel_dirty  ),
    .res_o       ( res        )
  );

  // Victims come only from the ways named in the request
  victim_select i_victim (
    .clk_i,
    .rst_i,
    .req_i       ( evict_req      ),
    .allowed_i   ( req_q.way_mask ),
    .tag_valid_i ( tag_val        ),
    .tag_dirty_i ( tag_dirty      ),
    .spm_lock_i,
    .victim_o    ( victim         ),
    .evict_o     ( evict_flag     ),
    .valid_o     ( victim_valid   )
  );

  resp_spill_reg i_spill (
    .clk_i,
    .rst_i,
    .valid_i ( res_valid ),
    .ready_o ( res_ready ),
    .data_i  ( res       ),
    .valid_o,
    .ready_i,
    .data_o  ( res_o     )
  );

endmodule

/* hw/resp_spill_reg.sv */
`timescale 1ns/1ps

module resp_spill_reg (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      valid_i,
  output logic                      ready_o,
  input  tag_store_pkg::store_res_t data_i,
  output logic                      valid_o,
  input  logic                      ready_i,
  output tag_store_pkg::store_res_t data_o
);

  import tag_store_pkg::*;

  // Slot occupied
  logic       full_q;
  // Held response
  store_res_t data_q;
  logic       load;

  // Room when empty, or when the held item leaves this cycle
  assign ready_o = ~full_q | ready_i;
  assign load    = valid_i & ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (ready_i) begin
      // Drained with nothing new behind it
      full_q <= 1'b0;
    end
  end

  // Stays put while the consumer stalls
  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= data_i;
    end
  end

  assign valid_o = full_q;
  assign data_o  = data_q;

endmodule

/* hw/tag_store_ctrl.sv */
`timescale 1ns/1ps

module tag_store_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  tag_store_pkg::store_req_t req_i,
  input  logic                      valid_i,
  input  llc_cfg_pkg::way_mask_t    rvalid_i,
  input  llc_cfg_pkg::way_mask_t    hit_i,
  input  logic                      sel_dirty_i,
  input  llc_cfg_pkg::way_mask_t    res_way_i,
  input  logic                      victim_valid_i,
  input  logic                      res_ready_i,
  output logic                      ready_o,
  output tag_store_pkg::store_req_t req_q_o,
  output llc_cfg_pkg::way_mask_t    ram_req_o,
  output llc_cfg_pkg::way_mask_t    ram_we_o,
  output llc_cfg_pkg::index_t       ram_index_o,
  output tag_store_pkg::tag_entry_t ram_wdata_o,
  output logic                      evict_req_o,
  output logic                      res_valid_o
);

  import llc_cfg_pkg::*;
  import tag_store_pkg::*;

  // Busy from acceptance until the response is taken
  logic       busy_q;
  logic       busy_d;
  // Request under work
  store_req_t req_q;
  logic       load_req;
  // Read token held until the response leaves
  way_mask_t  rvalid_q;
  // Victim already chosen for this miss
  logic       victim_held_q;
  logic       data_valid;
  logic       res_take;

  // Read data is fresh or still held
  assign data_valid = (|rvalid_i) | (|rvalid_q);
  assign res_take   = res_valid_o & res_ready_i;

  always_comb begin : proc_ctrl
    busy_d      = busy_q;
    ready_o     = 1'b0;
    load_req    = 1'b0;
    res_valid_o = 1'b0;
    evict_req_o = 1'b0;
    ram_req_o   = '0;
    ram_we_o    = '0;
    ram_index_o = '0;
    ram_wdata_o = '0;

    if (!busy_q) begin
      // Idle, take any request and read its ways
      ready_o = 1'b1;
      if (valid_i) begin
        busy_d      = 1'b1;
        load_req    = 1'b1;
        ram_req_o   = req_i.way_mask;
        ram_index_o = req_i.index;
      end
    end else if (req_q.mode == Lookup) begin
      if (data_valid) begin
        if (|hit_i) begin
          res_valid_o = 1'b1;
        end else begin
          // Miss needs a victim, ask only once
          evict_req_o = ~victim_held_q;
          res_valid_o = victim_valid_i | victim_held_q;
        end
      end

      // Update the array once the response is taken
      if (res_valid_o && res_ready_i) begin
        if (|hit_i) begin
          if (req_q.dirty && !sel_dirty_i) begin
            // Clean line becomes dirty
            ram_req_o   = res_way_i;
            ram_we_o    = res_way_i;
            ram_index_o = req_q.index;
            ram_wdata_o = '{valid: 1'b1, dirty: 1'b1, tag: req_q.tag};
            busy_d      = 1'b0;
          end else if (valid_i && (req_i.mode == Lookup)) begin
            // Nothing to write, chain the next Lookup
            ready_o     = 1'b1;
            load_req    = 1'b1;
            ram_req_o   = req_i.way_mask;
            ram_index_o = req_i.index;
          end else begin
            busy_d = 1'b0;
          end
        end else begin
          // Allocate the new tag in the victim way
          ram_req_o   = res_way_i;
          ram_we_o    = res_way_i;
          ram_index_o = req_q.index;
          ram_wdata_o = '{valid: 1'b1, dirty: req_q.dirty, tag: req_q.tag};
          busy_d      = 1'b0;
        end
      end
    end else begin
      // Flush answers as soon as the way is read
      if (data_valid) begin
        res_valid_o = 1'b1;
      end
      // Clear the entry once the response is taken
      if (res_valid_o && res_ready_i) begin
        ram_req_o   = req_q.way_mask;
        ram_we_o    = req_q.way_mask;
        ram_index_o = req_q.index;
        ram_wdata_o = '0;
        busy_d      = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q        <= 1'b0;
      rvalid_q      <= '0;
      victim_held_q <= 1'b0;
    end else begin
      busy_q <= busy_d;
      // Taking the response ends the token, a chained read brings a new one
      if (res_take) begin
        rvalid_q <= '0;
      end else if (|rvalid_i) begin
        rvalid_q <= rvalid_i;
      end
      if (res_take) begin
        victim_held_q <= 1'b0;
      end else if (evict_req_o && victim_valid_i) begin
        victim_held_q <= 1'b1;
      end
    end
  end

  // Request payload
  always_ff @(posedge clk_i) begin
    if (load_req) begin
      req_q <= req_i;
    end
  end

  assign req_q_o = req_q;

endmodule

/* hw/victim_select.sv */
`timescale 1ns/1ps

module victim_select (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   req_i,
  input  llc_cfg_pkg::way_mask_t allowed_i,
  input  llc_cfg_pkg::way_mask_t tag_valid_i,
  input  llc_cfg_pkg::way_mask_t tag_dirty_i,
  input  llc_cfg_pkg::way_mask_t spm_lock_i,
  output llc_cfg_pkg::way_mask_t victim_o,
  output logic                   evict_o,
  output logic                   valid_o
);

  import llc_cfg_pkg::*;

  way_mask_t eligible;
  way_mask_t free_ways;
  way_mask_t free_pick;
  way_mask_t rr_pick;
  way_mask_t pick;
  logic      pick_evict;
  // Round-robin pointer and its successor
  way_idx_t  ptr_q;
  way_idx_t  ptr_next;
  way_idx_t  rr_idx;
  // Choice kept after the request pulse
  way_mask_t victim_q;
  logic      evict_q;

  // Scratchpad ways are never replaced
  assign eligible  = allowed_i & ~spm_lock_i;
  assign free_ways = eligible & ~tag_valid_i;

  // Lowest set bit of the free ways
  assign free_pick = free_ways & (~free_ways + way_mask_t'(1));

  // First eligible way at or after the pointer
  // Walk offsets downwards so the smallest offset is the last to win
  always_comb begin : proc_rr
    int way;
    rr_pick = '0;
    rr_idx  = ptr_q;
    for (int n = NumWays - 1; n >= 0; n--) begin
      way = (int'(ptr_q) + n) % int'(NumWays);
      if (eligible[way]) begin
        rr_pick      = '0;
        rr_pick[way] = 1'b1;
        rr_idx       = way_idx_t'(way);
      end
    end
  end

  // Invalid ways go first
  assign pick       = (|free_ways) ? free_pick : rr_pick;
  assign pick_evict = |(pick & tag_valid_i & tag_dirty_i);

  // Pointer wraps after the last way
  assign ptr_next = (rr_idx == way_idx_t'(NumWays - 1)) ? '0 : rr_idx + 1'b1;

  // Answer in the request cycle, held value afterwards
  assign valid_o  = req_i & (|eligible);
  assign victim_o = req_i ? pick : victim_q;
  assign evict_o  = req_i ? pick_evict : evict_q;

  // Pointer only moves when the round-robin choice was used
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else if (valid_o && !(|free_ways)) begin
      ptr_q <= ptr_next;
    end
  end

  // Keep the choice stable while the response waits
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      victim_q <= pick;
      evict_q  <= pick_evict;
    end
  end

endmodule

/* hw/tag_match.sv */
`timescale 1ns/1ps

module tag_match (
  input  tag_store_pkg::tag_entry_t [llc_cfg_pkg::NumWays-1:0] rdata_i,
  input  tag_store_pkg::store_req_t                             req_q_i,
  input  llc_cfg_pkg::way_mask_t                                victim_i,
  input  logic                                                  evict_i,
  output llc_cfg_pkg::way_mask_t                                hit_o,
  output llc_cfg_pkg::way_mask_t                                val_o,
  output llc_cfg_pkg::way_mask_t                                dirty_o,
  output logic                                                  sel_dirty_o,
  output tag_store_pkg::store_res_t                             res_o
);

  import llc_cfg_pkg::*;
  import tag_store_pkg::*;

  // Way the response points at, one-hot
  way_mask_t  res_way;
  // Same way in binary
  way_idx_t   res_idx;
  // Stored entry of that way
  tag_entry_t sel_entry;
  logic       any_hit;

  // Per-way compare of the read data against the registered request
  for (genvar w = 0; w < NumWays; w++) begin : gen_cmp
    assign val_o[w]   = rdata_i[w].valid;
    assign dirty_o[w] = rdata_i[w].dirty;
    // Only masked, valid ways with equal tag count
    assign hit_o[w]   = req_q_i.way_mask[w] & rdata_i[w].valid &
                        (rdata_i[w].tag == req_q_i.tag);
  end

  assign any_hit = |hit_o;

  // Flush names its way, a Lookup uses the hit way or else the victim
  always_comb begin
    if (req_q_i.mode == Flush) begin
      res_way = req_q_i.way_mask;
    end else if (any_hit) begin
      res_way = hit_o;
    end else begin
      res_way = victim_i;
    end
  end

  // One-hot to binary by OR of set positions
  always_comb begin
    res_idx = '0;
    for (int w = 0; w < NumWays; w++) begin
      if (res_way[w]) begin
        res_idx = res_idx | way_idx_t'(w);
      end
    end
  end

  assign sel_entry   = rdata_i[res_idx];
  // ctrl needs this to decide on the dirty update after a hit
  assign sel_dirty_o = sel_entry.dirty;

  // Response forming
  always_comb begin
    res_o          = '0;
    res_o.way_mask = res_way;
    if (req_q_i.mode == Flush) begin
      // Write back only what is valid and dirty
      res_o.evict     = sel_entry.valid & sel_entry.dirty;
      res_o.evict_tag = sel_entry.tag;
    end else if (any_hit) begin
      res_o.hit = 1'b1;
    end else begin
      // Miss, the victim's old line may need a write back
      res_o.evict     = evict_i;
      res_o.evict_tag = sel_entry.tag;
    end
  end

endmodule

/* hw/tag_array.sv */
`timescale 1ns/1ps

module tag_array (
  input  logic                                                  clk_i,
  input  logic                                                  rst_i,
  input  llc_cfg_pkg::way_mask_t                                req_i,
  input  llc_cfg_pkg::way_mask_t                                we_i,
  input  llc_cfg_pkg::index_t                                   index_i,
  input  tag_store_pkg::tag_entry_t                             wdata_i,
  output tag_store_pkg::tag_entry_t [llc_cfg_pkg::NumWays-1:0] rdata_o,
  output llc_cfg_pkg::way_mask_t                                rvalid_o
);

  import llc_cfg_pkg::*;
  import tag_store_pkg::*;

  // One bank per way, all banks share index and write data
  for (genvar w = 0; w < NumWays; w++) begin : gen_way
    // Entries of this way, one per set
    tag_entry_t            mem_q  [NumSets];
    // Read data stages
    tag_entry_t            data_q [TagLatency];
    // Read-valid token stages
    logic [TagLatency-1:0] tok_q;
    logic                  rd_en;
    logic                  wr_en;

    // Strobe without write enable is a read
    assign rd_en = req_i[w] & ~we_i[w];
    assign wr_en = req_i[w] & we_i[w];

    // Storage, empty after reset
    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        for (int s = 0; s < NumSets; s++) begin
          mem_q[s] <= '0;
        end
      end else if (wr_en) begin
        mem_q[index_i] <= wdata_i;
      end
    end

    // Token travels alongside the data, one pulse per read
    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        tok_q <= '0;
      end else begin
        tok_q[0] <= rd_en;
        for (int k = 1; k < TagLatency; k++) begin
          tok_q[k] <= tok_q[k-1];
        end
      end
    end

    // Stages only advance with their token
    // Last stage keeps its value until the next read arrives
    always_ff @(posedge clk_i) begin
      if (rd_en) begin
        data_q[0] <= mem_q[index_i];
      end
      for (int k = 1; k < TagLatency; k++) begin
        if (tok_q[k-1]) begin
          data_q[k] <= data_q[k-1];
        end
      end
    end

    assign rdata_o[w]  = data_q[TagLatency-1];
    assign rvalid_o[w] = tok_q[TagLatency-1];
  end

endmodule

/* hw/tag_store_pkg.sv */
package tag_store_pkg;

  // Request kinds

  // Lookup compares and allocates on a miss
  // Flush reads one way and clears it
  typedef enum logic {
    Lookup = 1'b0,
    Flush  = 1'b1
  } store_mode_e;

  // Stored entry

  // Content of one way for one set
  typedef struct packed {
    // Line holds data
    logic              valid;
    // Line differs from memory
    logic              dirty;
    // Address tag of the line
    llc_cfg_pkg::tag_t tag;
  } tag_entry_t;

  // Request into the tag store
  typedef struct packed {
    // Lookup or Flush
    store_mode_e            mode;
    // Ways taking part, a single way for a Flush
    llc_cfg_pkg::way_mask_t way_mask;
    // Set to access
    llc_cfg_pkg::index_t    index;
    // Tag to compare against, or to allocate
    llc_cfg_pkg::tag_t      tag;
    // Access will dirty the line
    logic                   dirty;
  } store_req_t;

  // Response from the tag store
  typedef struct packed {
    // One-hot way the response refers to
    llc_cfg_pkg::way_mask_t way_mask;
    // Lookup found the tag
    logic                   hit;
    // Old line in way_mask must be written back
    logic                   evict;
    // Tag of the line to write back
    llc_cfg_pkg::tag_t      evict_tag;
  } store_res_t;

endpackage

/* hw/llc_cfg_pkg.sv */
package llc_cfg_pkg;

  // Cache geometry

  // Ways per set
  localparam int unsigned NumWays = 4;
  // Sets in every way
  localparam int unsigned NumSets = 16;
  // Width of the stored tag, without the status bits
  localparam int unsigned TagWidth = 10;
  // Cycles from a read strobe to valid read data
  localparam int unsigned TagLatency = 1;

  // Derived widths
  // Set index into one tag bank
  localparam int unsigned IndexWidth = (NumSets > 1) ? $clog2(NumSets) : 1;
  // Binary way number
  localparam int unsigned WayIdxWidth = (NumWays > 1) ? $clog2(NumWays) : 1;

  // Shared types

  // Set index, also the bank address
  typedef logic [IndexWidth-1:0] index_t;

  // Address tag of one line
  typedef logic [TagWidth-1:0] tag_t;

  // One bit per way, used for requests, hits and the chosen way
  typedef logic [NumWays-1:0] way_mask_t;

  // Way number in binary, selects one bank's read data
  typedef logic [WayIdxWidth-1:0] way_idx_t;

endpackage
